// File: hw/bb_bus_pkg.sv
// Wishbone B3 bus definitions for the debug RAM
// Bus widths for address, data and byte selects
// Cycle type and burst type codes
// Request struct driven by the master
// Response struct returned by the slave
`default_nettype none

package bb_bus_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int DATA_W = 32;
  localparam int ADR_W  = 32;
  localparam int SEL_W  = DATA_W / 8;

  ////////////////////
  // Cycle and burst codes
  ////////////////////

  // Cycle type identifier on cti
  typedef enum logic [2:0] {
    CTI_CLASSIC     = 3'b000,
    CTI_CONST_BURST = 3'b001,
    CTI_INCR_BURST  = 3'b010,
    CTI_END_BURST   = 3'b111
  } cti_e;

  // Burst type extension on bte
  // Only meaningful with an incrementing burst
  typedef enum logic [1:0] {
    BTE_LINEAR = 2'b00,
    BTE_WRAP4  = 2'b01,
    BTE_WRAP8  = 2'b10,
    BTE_WRAP16 = 2'b11
  } bte_e;

  ////////////////////
  // Bus structs
  ////////////////////

  // Everything the master drives
  typedef struct packed {
    logic [ADR_W-1:0]  adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
    logic              we;
    bte_e              bte;
    cti_e              cti;
    logic              cyc;
    logic              stb;
  } bb_req_t;

  // Slave answer
  // Retry is not part of it
  typedef struct packed {
    logic [DATA_W-1:0] dat;
    logic              ack;
    logic              err;
  } bb_rsp_t;

endpackage

`default_nettype wire

// File: hw/bb_mem_pkg.sv
// Memory geometry defaults for the debug RAM
// Byte address width and size of the array
// Byte offset width dropped to form a word index
`default_nettype none

package bb_mem_pkg;

  // Byte address bits decoded by the RAM
  localparam int DEF_MEM_ADR_W = 15;

  // 20 KB of storage
  localparam int DEF_MEM_BYTES = 32'h0000_5000;

  // Byte offset inside a 32 bit word
  // Word index = byte address >> WORD_OFS_W
  localparam int WORD_OFS_W = 2;

endpackage

`default_nettype wire

// File: hw/bb_cycle_ctrl.sv
// Cycle control for the debug RAM
// Burst in progress flag with start and stop decode
// Registered feedback acknowledge per cycle type
// Out of range address decode
// Split of the feedback pulse into ack or err
`timescale 1ns/1ps
`default_nettype none

module bb_cycle_ctrl #(
  parameter int MEM_ADR_W = 15
) (
  input  wire logic                bb_clk_i,
  input  wire logic                bb_rst_i,
  input  wire bb_bus_pkg::bb_req_t req_i,
  input  wire logic                adr_drift_i,
  output logic                     burst_start_o,
  output logic                     burst_active_o,
  output logic                     ack_o,
  output logic                     err_o
);

  ////////////////////
  // Decode
  ////////////////////

  // Burst in progress
  logic burst_q;
  // Registered feedback pulse
  logic fb_q;
  // Cycle type groups
  logic is_burst_cti;
  logic is_end_cti;
  // Error sources
  logic adr_err;
  logic any_err;
  logic burst_stop;

  // Constant or incrementing address burst
  assign is_burst_cti = (req_i.cti == bb_bus_pkg::CTI_CONST_BURST) |
                        (req_i.cti == bb_bus_pkg::CTI_INCR_BURST);
  assign is_end_cti   = (req_i.cti == bb_bus_pkg::CTI_END_BURST);

  // Address beyond the array
  // Top nibble skipped so the RAM can sit at any base
  assign adr_err = req_i.cyc & req_i.stb &
                   (|req_i.adr[bb_bus_pkg::ADR_W-5:MEM_ADR_W]);
  assign any_err = adr_err | adr_drift_i;

  // New burst on the first strobe of a burst type
  assign burst_start_o = is_burst_cti & req_i.stb & req_i.cyc & ~burst_q;

  // Acked end beat or any error ends the burst
  assign burst_stop = (is_end_cti & req_i.stb & burst_q & ack_o) | err_o;

  ////////////////////
  // Burst flag
  ////////////////////

  always_ff @(posedge bb_clk_i) begin
    if (bb_rst_i) begin
      burst_q <= 1'b0;
    end else if (burst_start_o) begin
      burst_q <= 1'b1;
    end else if (burst_stop) begin
      burst_q <= 1'b0;
    end
  end

  assign burst_active_o = burst_q;

  ////////////////////
  // Feedback register
  ////////////////////

  always_ff @(posedge bb_clk_i) begin
    if (bb_rst_i) begin
      fb_q <= 1'b0;
    end else if (req_i.cyc) begin
      if (adr_err) begin
        // Single err pulse per strobe
        fb_q <= ~fb_q;
      end else begin
        case (req_i.cti)
          // Classic beat takes two clocks
          bb_bus_pkg::CTI_CLASSIC:     fb_q <= req_i.stb ^ fb_q;
          // Bursts ack every strobe after the first
          bb_bus_pkg::CTI_CONST_BURST: fb_q <= req_i.stb;
          bb_bus_pkg::CTI_INCR_BURST:  fb_q <= req_i.stb;
          // Last beat gets one pulse only
          bb_bus_pkg::CTI_END_BURST:   fb_q <= req_i.stb & ~fb_q;
          default:                     fb_q <= fb_q;
        endcase
      end
    end else begin
      // Bus released
      fb_q <= 1'b0;
    end
  end

  ////////////////////
  // Response split
  ////////////////////

  // Err takes the slot of the ack
  assign ack_o = fb_q & req_i.stb & ~any_err;
  assign err_o = fb_q & req_i.stb & any_err;

endmodule

`default_nettype wire

// File: hw/bb_burst_adr.sv
// Burst address generation for the debug RAM
// Registered copies of the burst and cycle type
// Word address register loaded from the bus
// Burst counter with linear and wrapping increments
// Drift check of the bus address against the counter
`timescale 1ns/1ps
`default_nettype none

module bb_burst_adr #(
  parameter int MEM_ADR_W = 15
) (
  input  wire logic                 bb_clk_i,
  input  wire logic                 bb_rst_i,
  input  wire bb_bus_pkg::bb_req_t  req_i,
  input  wire logic                 burst_start_i,
  input  wire logic                 burst_active_i,
  input  wire logic                 ack_i,
  output logic [MEM_ADR_W-bb_mem_pkg::WORD_OFS_W-1:0] word_adr_o,
  output logic                      adr_drift_o
);

  localparam int WADR_W = MEM_ADR_W - bb_mem_pkg::WORD_OFS_W;

  // Bus types seen one clock earlier
  bb_bus_pkg::bte_e bte_q;
  bb_bus_pkg::cti_e cti_q;
  // Word address from the bus
  logic [WADR_W-1:0] bus_wadr;
  // Current and next word address
  logic [WADR_W-1:0] wadr_q;
  logic [WADR_W-1:0] wadr_nxt;
  logic              incr_beat;

  assign bus_wadr = req_i.adr[MEM_ADR_W-1:bb_mem_pkg::WORD_OFS_W];

  ////////////////////
  // Type registers
  ////////////////////

  always_ff @(posedge bb_clk_i) begin
    if (bb_rst_i) begin
      bte_q <= bb_bus_pkg::BTE_LINEAR;
      cti_q <= bb_bus_pkg::CTI_CLASSIC;
    end else begin
      bte_q <= req_i.bte;
      cti_q <= req_i.cti;
    end
  end

  ////////////////////
  // Burst counter
  ////////////////////

  // Acked beat of a running incrementing burst
  assign incr_beat = (cti_q == bb_bus_pkg::CTI_INCR_BURST) & ack_i & burst_active_i;

  always_comb begin
    wadr_nxt = wadr_q;
    if (burst_start_i) begin
      // Counter starts at the bus address
      wadr_nxt = bus_wadr;
    end else if (incr_beat) begin
      // Wrap modes keep the upper bits fixed
      case (bte_q)
        bb_bus_pkg::BTE_LINEAR: wadr_nxt      = wadr_q + 1'b1;
        bb_bus_pkg::BTE_WRAP4:  wadr_nxt[1:0] = wadr_q[1:0] + 2'd1;
        bb_bus_pkg::BTE_WRAP8:  wadr_nxt[2:0] = wadr_q[2:0] + 3'd1;
        bb_bus_pkg::BTE_WRAP16: wadr_nxt[3:0] = wadr_q[3:0] + 4'd1;
        default:                wadr_nxt      = wadr_q;
      endcase
    end
  end

  ////////////////////
  // Address register
  ////////////////////

  always_ff @(posedge bb_clk_i) begin
    if (bb_rst_i) begin
      wadr_q <= '0;
    end else if (burst_active_i | burst_start_i) begin
      wadr_q <= wadr_nxt;
    end else if (req_i.cyc & req_i.stb) begin
      // Classic access takes the bus address
      wadr_q <= bus_wadr;
    end
  end

  assign word_adr_o = wadr_q;

  // Master left the burst sequence
  assign adr_drift_o = burst_active_i & (wadr_q != bus_wadr);

endmodule

`default_nettype wire

// File: hw/bb_word_store.sv
// Word storage for the debug RAM
// Block style array of 32 bit words
// Byte lane merge for partial writes
// Asynchronous read from the registered word address
`timescale 1ns/1ps
`default_nettype none

module bb_word_store #(
  parameter int MEM_ADR_W = 15,
  parameter int MEM_BYTES = 32'h0000_5000
) (
  input  wire logic                                      bb_clk_i,
  input  wire logic [MEM_ADR_W-bb_mem_pkg::WORD_OFS_W-1:0] word_adr_i,
  input  wire logic [bb_bus_pkg::DATA_W-1:0]             wr_dat_i,
  input  wire logic [bb_bus_pkg::SEL_W-1:0]              sel_i,
  input  wire logic                                      wr_en_i,
  output logic      [bb_bus_pkg::DATA_W-1:0]             rd_dat_o
);

  localparam int MEM_WORDS = MEM_BYTES / bb_bus_pkg::SEL_W;

  // Storage array
  logic [bb_bus_pkg::DATA_W-1:0] mem [MEM_WORDS];
  // Word after the byte lane merge
  logic [bb_bus_pkg::DATA_W-1:0] merged;

  ////////////////////
  // Read
  ////////////////////

  // No added latency behind the address register
  assign rd_dat_o = mem[word_adr_i];

  ////////////////////
  // Write
  ////////////////////

  // Unselected lanes keep the stored byte
  always_comb begin
    for (int b = 0; b < bb_bus_pkg::SEL_W; b++) begin
      merged[8*b +: 8] = sel_i[b] ? wr_dat_i[8*b +: 8] : rd_dat_o[8*b +: 8];
    end
  end

  always_ff @(posedge bb_clk_i) begin
    if (wr_en_i) begin
      mem[word_adr_i] <= merged;
    end
  end

endmodule

`default_nettype wire

// File: hw/bb_ram_top.sv
// Debug scratch RAM top level
// Wishbone B3 slave with registered feedback
// Cycle control, burst address and word storage blocks
// Response struct packing
`timescale 1ns/1ps
`default_nettype none

module bb_ram_top #(
  parameter int MEM_ADR_W = bb_mem_pkg::DEF_MEM_ADR_W,
  parameter int MEM_BYTES = bb_mem_pkg::DEF_MEM_BYTES
) (
  input  wire logic                bb_clk_i,
  input  wire logic                bb_rst_i,
  input  wire bb_bus_pkg::bb_req_t bus_req_i,
  output bb_bus_pkg::bb_rsp_t      bus_rsp_o
);

  localparam int WADR_W = MEM_ADR_W - bb_mem_pkg::WORD_OFS_W;

  // Burst decode from cycle control
  logic burst_start;
  logic burst_active;
  // Bus answer
  logic ack;
  logic err;
  // Address block outputs
  logic [WADR_W-1:0] word_adr;
  logic              adr_drift;
  // Storage side
  logic                          wr_en;
  logic [bb_bus_pkg::DATA_W-1:0] rd_dat;

  ////////////////////
  // Cycle control
  ////////////////////

  bb_cycle_ctrl #(
    .MEM_ADR_W(MEM_ADR_W)
  ) cycle_ctrl_i (
    .bb_clk_i      (bb_clk_i),
    .bb_rst_i      (bb_rst_i),
    .req_i         (bus_req_i),
    .adr_drift_i   (adr_drift),
    .burst_start_o (burst_start),
    .burst_active_o(burst_active),
    .ack_o         (ack),
    .err_o         (err)
  );

  ////////////////////
  // Burst address
  ////////////////////

  bb_burst_adr #(
    .MEM_ADR_W(MEM_ADR_W)
  ) burst_adr_i (
    .bb_clk_i      (bb_clk_i),
    .bb_rst_i      (bb_rst_i),
    .req_i         (bus_req_i),
    .burst_start_i (burst_start),
    .burst_active_i(burst_active),
    .ack_i         (ack),
    .word_adr_o    (word_adr),
    .adr_drift_o   (adr_drift)
  );

  ////////////////////
  // Storage
  ////////////////////

  // Write on an acked write beat
  assign wr_en = bus_req_i.we & ack;

  bb_word_store #(
    .MEM_ADR_W(MEM_ADR_W),
    .MEM_BYTES(MEM_BYTES)
  ) word_store_i (
    .bb_clk_i  (bb_clk_i),
    .word_adr_i(word_adr),
    .wr_dat_i  (bus_req_i.dat),
    .sel_i     (bus_req_i.sel),
    .wr_en_i   (wr_en),
    .rd_dat_o  (rd_dat)
  );

  assign bus_rsp_o = '{dat: rd_dat, ack: ack, err: err};

endmodule

`default_nettype wire

// File: verif/bb_ram_tb_tasks.svh
// Testbench helpers for the debug RAM
// LFSR random source, one step per bit
// Address helpers with the wrap rule
// Bus beat driver with a bounded wait for ack or err
// Shadow memory update with the byte lane merge
`ifndef BB_RAM_TB_TASKS_SVH
`define BB_RAM_TB_TASKS_SVH

////////////////////
// Random source
////////////////////

// x^16 + x^15 + x^13 + x^4 + 1
function automatic logic lfsr_step();
  logic fb;
  fb = lfsr_q[15] ^ lfsr_q[14] ^ lfsr_q[12] ^ lfsr_q[3];
  lfsr_q = {lfsr_q[14:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_step()};
  end
  return v;
endfunction

////////////////////
// Address and data rules
////////////////////

function automatic logic [31:0] byte_adr(input logic [WADR_W-1:0] w);
  return 32'(w) << bb_mem_pkg::WORD_OFS_W;
endfunction

// Wrap bursts step only the low bits
function automatic logic [WADR_W-1:0] next_wadr(input logic [WADR_W-1:0] w,
                                                input bb_bus_pkg::bte_e bte);
  case (bte)
    bb_bus_pkg::BTE_WRAP4:  return {w[WADR_W-1:2], 2'(w[1:0] + 2'd1)};
    bb_bus_pkg::BTE_WRAP8:  return {w[WADR_W-1:3], 3'(w[2:0] + 3'd1)};
    bb_bus_pkg::BTE_WRAP16: return {w[WADR_W-1:4], 4'(w[3:0] + 4'd1)};
    default:                return WADR_W'(w + 1'b1);
  endcase
endfunction

// Selected lanes from the bus, the rest kept
function automatic logic [31:0] merge_lanes(input logic [31:0] old_w, input logic [31:0] new_w,
                                            input logic [3:0] sel);
  logic [31:0] m;
  for (int b = 0; b < 4; b++) begin
    m[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
  end
  return m;
endfunction

////////////////////
// Bus driving
////////////////////

// Called on a falling edge, returns on the falling edge after the beat
task automatic bus_beat(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel,
                        input logic we, input bb_bus_pkg::cti_e cti,
                        input bb_bus_pkg::bte_e bte, output int waits, output logic got_err);
  bus_req.adr = adr;
  bus_req.dat = dat;
  bus_req.sel = sel;
  bus_req.we  = we;
  bus_req.cti = cti;
  bus_req.bte = bte;
  bus_req.cyc = 1'b1;
  bus_req.stb = 1'b1;
  exp_wadr    = adr[MEM_ADR_W-1:bb_mem_pkg::WORD_OFS_W];
  waits       = 0;
  // Look a quarter period in, away from both edges
  #(CLK_PERIOD / 4);
  while (!bus_rsp.ack && !bus_rsp.err && waits < TIMEOUT) begin
    @(negedge bb_clk);
    #(CLK_PERIOD / 4);
    waits++;
  end
  if (!bus_rsp.ack && !bus_rsp.err) begin
    timeouts++;
    $display("timeout: no ack or err within %0d cycles for address %h", TIMEOUT, adr);
  end
  got_err = bus_rsp.err;
  if (bus_rsp.ack && we) begin
    shadow[exp_wadr] = merge_lanes(shadow[exp_wadr], dat, sel);
  end
  @(negedge bb_clk);
endtask

task automatic bus_idle();
  bus_req.cyc = 1'b0;
  bus_req.stb = 1'b0;
  bus_req.we  = 1'b0;
  bus_req.cti = bb_bus_pkg::CTI_CLASSIC;
  @(negedge bb_clk);
endtask

`endif

// File: verif/bb_ram_tb.sv
// Testbench for the debug scratch RAM
// Clock, reset and DUT instance
// Shadow memory and concurrent bus checks
// Classic, partial, burst, range and drift sequences
// Closing report
`timescale 1ns/1ps
`default_nettype none

module bb_ram_tb;

  localparam int CLK_PERIOD = 8;
  localparam int TIMEOUT    = 20;
  localparam int MEM_ADR_W  = bb_mem_pkg::DEF_MEM_ADR_W;
  localparam int WADR_W     = MEM_ADR_W - bb_mem_pkg::WORD_OFS_W;
  localparam int MEM_WORDS  = bb_mem_pkg::DEF_MEM_BYTES / 4;
  // Undecoded bits from MEM_ADR_W up to the top nibble
  localparam int OOR_BITS   = bb_bus_pkg::ADR_W - 4 - MEM_ADR_W;

  logic                bb_clk;
  logic                bb_rst;
  bb_bus_pkg::bb_req_t bus_req;
  bb_bus_pkg::bb_rsp_t bus_rsp;

  // Shadow of the array and the word the bus points at
  logic [31:0]       shadow [MEM_WORDS];
  logic [WADR_W-1:0] exp_wadr;
  logic [31:0]       exp_rd;
  logic              req_oor;
  logic [15:0]       lfsr_q;
  int                check_errs;
  int                timeouts;
  logic [WADR_W-1:0] used_wadr [8];

  `include "bb_ram_tb_tasks.svh"

  bb_ram_top #(
    .MEM_ADR_W(MEM_ADR_W),
    .MEM_BYTES(bb_mem_pkg::DEF_MEM_BYTES)
  ) dut_i (
    .bb_clk_i (bb_clk),
    .bb_rst_i (bb_rst),
    .bus_req_i(bus_req),
    .bus_rsp_o(bus_rsp)
  );

  initial begin
    bb_clk = 1'b0;
    forever #(CLK_PERIOD / 2) bb_clk = ~bb_clk;
  end

  assign exp_rd  = shadow[exp_wadr];
  assign req_oor = |bus_req.adr[bb_bus_pkg::ADR_W-5:MEM_ADR_W];

  ////////////////////
  // Bus checks
  ////////////////////

  task automatic check_resp(input int waits, input logic got_err, input int exp_waits,
                            input logic exp_err);
    assert (got_err == exp_err) else begin
      check_errs++;
      $display("error bus_rsp.err: got %h expected %h at adr %h", got_err, exp_err, bus_req.adr);
    end
    assert (waits == exp_waits) else begin
      check_errs++;
      $display("error bus_rsp.ack delay: got %h expected %h", waits, exp_waits);
    end
  endtask

  task automatic classic_access(input logic [31:0] adr, input logic [31:0] dat,
                                input logic [3:0] sel, input logic we, input logic exp_err);
    int   waits;
    logic got_err;
    bus_beat(adr, dat, sel, we, bb_bus_pkg::CTI_CLASSIC, bb_bus_pkg::BTE_LINEAR,
             waits, got_err);
    check_resp(waits, got_err, 1, exp_err);
    bus_idle();
  endtask

  task automatic run_burst(input logic [WADR_W-1:0] start, input int beats, input logic we,
                           input bb_bus_pkg::bte_e bte);
    logic [WADR_W-1:0] w;
    bb_bus_pkg::cti_e  cti;
    int                waits;
    logic              got_err;
    w = start;
    for (int i = 0; i < beats; i++) begin
      cti = (i == beats - 1) ? bb_bus_pkg::CTI_END_BURST : bb_bus_pkg::CTI_INCR_BURST;
      bus_beat(byte_adr(w), we ? rand_bits(32) : '0, 4'hF, we, cti, bte, waits, got_err);
      // Only the first beat waits on the feedback register
      check_resp(waits, got_err, (i == 0) ? 1 : 0, 1'b0);
      w = next_wadr(w, bte);
    end
    bus_idle();
  endtask

  rd_data_chk: assert property (@(posedge bb_clk) disable iff (bb_rst)
    (bus_rsp.ack && !bus_req.we) |-> (bus_rsp.dat == exp_rd))
  else begin
    check_errs++;
    $display("error bus_rsp.dat: got %h expected %h", $sampled(bus_rsp.dat), $sampled(exp_rd));
  end

  ack_err_chk: assert property (@(posedge bb_clk) disable iff (bb_rst)
    !(bus_rsp.ack && bus_rsp.err))
  else begin
    check_errs++;
    $display("error bus_rsp.ack and bus_rsp.err both high: %h %h",
             $sampled(bus_rsp.ack), $sampled(bus_rsp.err));
  end

  // Classic beats need the feedback register to drop in between
  classic_gap_chk: assert property (@(posedge bb_clk) disable iff (bb_rst)
    (bus_rsp.ack && bus_req.cti == bb_bus_pkg::CTI_CLASSIC) |=> !bus_rsp.ack)
  else begin
    check_errs++;
    $display("error bus_rsp.ack: %h in the cycle after a classic ack", $sampled(bus_rsp.ack));
  end

  oor_err_chk: assert property (@(posedge bb_clk) disable iff (bb_rst)
    (bus_req.cyc && bus_req.stb && req_oor && !bus_rsp.err) |=> bus_rsp.err)
  else begin
    check_errs++;
    $display("error bus_rsp.err: %h after strobe to out of range adr %h",
             $sampled(bus_rsp.err), $sampled(bus_req.adr));
  end

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    logic [WADR_W-1:0] w;
    logic [31:0]       oor_adr;
    int                waits;
    logic              got_err;
    bus_req    = '0;
    bb_rst     = 1'b1;
    lfsr_q     = 16'd23;
    exp_wadr   = '0;
    check_errs = 0;
    timeouts   = 0;
    repeat (16) @(posedge bb_clk);
    @(negedge bb_clk);
    bb_rst = 1'b0;
    @(negedge bb_clk);

    // Full word writes then read back
    for (int i = 0; i < 8; i++) begin
      used_wadr[i] = WADR_W'(rand_bits(12));
      classic_access(byte_adr(used_wadr[i]), rand_bits(32), 4'hF, 1'b1, 1'b0);
    end
    // Back to back reads with stb held between beats
    for (int i = 0; i < 8; i++) begin
      bus_beat(byte_adr(used_wadr[i]), '0, 4'hF, 1'b0, bb_bus_pkg::CTI_CLASSIC,
               bb_bus_pkg::BTE_LINEAR, waits, got_err);
      check_resp(waits, got_err, 1, 1'b0);
    end
    bus_idle();

    // Partial writes over initialized words
    for (int i = 0; i < 8; i++) begin
      classic_access(byte_adr(used_wadr[i]), rand_bits(32), 4'(rand_bits(4)), 1'b1, 1'b0);
      classic_access(byte_adr(used_wadr[i]), '0, 4'hF, 1'b0, 1'b0);
    end

    // Linear 8 beat burst
    w = WADR_W'(rand_bits(12));
    run_burst(w, 8, 1'b1, bb_bus_pkg::BTE_LINEAR);
    run_burst(w, 8, 1'b0, bb_bus_pkg::BTE_LINEAR);

    // Wrap bursts entered mid block
    w = WADR_W'((rand_bits(10) << 2) | 32'd2);
    run_burst(w, 4, 1'b1, bb_bus_pkg::BTE_WRAP4);
    run_burst(w, 4, 1'b0, bb_bus_pkg::BTE_WRAP4);
    w = WADR_W'((rand_bits(9) << 3) | 32'd5);
    run_burst(w, 8, 1'b1, bb_bus_pkg::BTE_WRAP8);
    run_burst(w, 8, 1'b0, bb_bus_pkg::BTE_WRAP8);

    // Out of range write leaves the aliased word alone
    w = WADR_W'(rand_bits(12));
    classic_access(byte_adr(w), rand_bits(32), 4'hF, 1'b1, 1'b0);
    oor_adr = byte_adr(w) | (32'd1 << (MEM_ADR_W + rand_bits(4) % OOR_BITS));
    classic_access(oor_adr, rand_bits(32), 4'hF, 1'b1, 1'b1);
    classic_access(byte_adr(w), '0, 4'hF, 1'b0, 1'b0);
    // Top nibble not decoded
    classic_access(byte_adr(w) | 32'hA000_0000, '0, 4'hF, 1'b0, 1'b0);

    // Second beat off the counter
    w = WADR_W'(rand_bits(12));
    bus_beat(byte_adr(w), rand_bits(32), 4'hF, 1'b1, bb_bus_pkg::CTI_INCR_BURST,
             bb_bus_pkg::BTE_LINEAR, waits, got_err);
    check_resp(waits, got_err, 1, 1'b0);
    bus_beat(byte_adr(WADR_W'(w + 3)), rand_bits(32), 4'hF, 1'b1,
             bb_bus_pkg::CTI_INCR_BURST, bb_bus_pkg::BTE_LINEAR, waits, got_err);
    check_resp(waits, got_err, 0, 1'b1);
    bus_idle();
    classic_access(byte_adr(w), '0, 4'hF, 1'b0, 1'b0);

    repeat (2) @(negedge bb_clk);
    $display("summary: check failures %0d, timeouts %0d", check_errs, timeouts);
    if (check_errs == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verif
hw/bb_bus_pkg.sv
hw/bb_mem_pkg.sv
hw/bb_cycle_ctrl.sv
hw/bb_burst_adr.sv
hw/bb_word_store.sv
hw/bb_ram_top.sv
verif/bb_ram_tb.sv
